// ==== hdl/core_consts.svh ====
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// ********************
// Core dimensions
// ********************

`define XLEN_W 32
`define REG_ADDR_W 5
`define NUM_REGS 32

// ********************
// Fixed encodings
// ********************

// First fetch address after reset.
`define RESET_PC 32'h0000_0000

// EBREAK stops the core without retiring.
`define INSN_EBREAK 32'h0010_0073

`endif

// ==== hdl/isa_pkg.sv ====
package isa_pkg;

	// Major opcodes of the supported RV32I subset.
	typedef enum logic [6:0] {
		OP_LUI    = 7'b0110111,
		OP_AUIPC  = 7'b0010111,
		OP_JAL    = 7'b1101111,
		OP_JALR   = 7'b1100111,
		OP_BRANCH = 7'b1100011,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_IMM    = 7'b0010011,
		OP_REG    = 7'b0110011,
		OP_SYSTEM = 7'b1110011
	} opcode_t;

	// ALU operations, one per arithmetic or logic function.
	typedef enum logic [3:0] {
		ALU_ADD    = 4'd0,
		ALU_SUB    = 4'd1,
		ALU_SLL    = 4'd2,
		ALU_SLT    = 4'd3,
		ALU_SLTU   = 4'd4,
		ALU_XOR    = 4'd5,
		ALU_SRL    = 4'd6,
		ALU_SRA    = 4'd7,
		ALU_OR     = 4'd8,
		ALU_AND    = 4'd9,
		ALU_PASS_B = 4'd10
	} alu_op_t;

	// Conditions that redirect the PC away from pc + 4.
	typedef enum logic [2:0] {
		BR_NONE   = 3'd0,
		BR_EQ     = 3'd1,
		BR_NE     = 3'd2,
		BR_LT     = 3'd3,
		BR_GE     = 3'd4,
		BR_LTU    = 3'd5,
		BR_GEU    = 3'd6,
		BR_ALWAYS = 3'd7
	} branch_t;

endpackage

// ==== hdl/core_pkg.sv ====
package core_pkg;

	// Source of the value written back at retire.
	typedef enum logic [1:0] {
		RES_NONE = 2'd0,
		RES_ALU  = 2'd1,
		RES_LINK = 2'd2,
		RES_MEM  = 2'd3
	} res_src_t;

	// Fetch unit state.
	// WAIT means an instruction request is open, BUSY means the
	// instruction is somewhere in decode, execute or memory.
	typedef enum logic [1:0] {
		FS_IDLE = 2'd0,
		FS_WAIT = 2'd1,
		FS_BUSY = 2'd2,
		FS_HALT = 2'd3
	} fetch_state_t;

endpackage

// ==== hdl/fetch_unit.sv ====
`timescale 1ns/1ps
`include "core_consts.svh"

module fetch_unit import core_pkg::*; (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               imem_rvalid,
	input  logic [`XLEN_W-1:0] imem_rdata,
	input  logic               retire,
	input  logic [`XLEN_W-1:0] next_pc,
	input  logic               halt_req,
	input  logic               illegal_req,
	output logic               imem_req,
	output logic [`XLEN_W-1:0] imem_addr,
	output logic               fetch_valid,
	output logic [`XLEN_W-1:0] fetch_pc,
	output logic [`XLEN_W-1:0] fetch_insn,
	output logic               halted,
	output logic               illegal
);

	fetch_state_t state;
	logic [`XLEN_W-1:0] pc;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= FS_IDLE;
			pc          <= `RESET_PC;
			imem_req    <= 1'b0;
			fetch_valid <= 1'b0;
			illegal     <= 1'b0;
		end else begin
			imem_req    <= 1'b0;
			fetch_valid <= 1'b0;
			case (state)
				FS_IDLE: begin
					imem_req <= 1'b1;
					state    <= FS_WAIT;
				end
				FS_WAIT: begin
					if (imem_rvalid) begin
						fetch_valid <= 1'b1;
						state       <= FS_BUSY;
					end
				end
				FS_BUSY: begin
					// A halting instruction never retires, so the two cannot collide.
					if (halt_req) begin
						illegal <= illegal_req;
						state   <= FS_HALT;
					end else if (retire) begin
						pc       <= next_pc;
						imem_req <= 1'b1;
						state    <= FS_WAIT;
					end
				end
				default: state <= FS_HALT;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == FS_WAIT && imem_rvalid) begin
			fetch_pc   <= pc;
			fetch_insn <= imem_rdata;
		end
	end

	assign imem_addr = pc;
	assign halted    = (state == FS_HALT);

	a_rvalid_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
		imem_rvalid |-> state == FS_WAIT);

endmodule

// ==== hdl/decode_unit.sv ====
`timescale 1ns/1ps
`include "core_consts.svh"

module decode_unit import isa_pkg::*, core_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  fetch_valid,
	input  logic [`XLEN_W-1:0]    fetch_pc,
	input  logic [`XLEN_W-1:0]    fetch_insn,
	input  logic [`XLEN_W-1:0]    rs1_data,
	input  logic [`XLEN_W-1:0]    rs2_data,
	output logic [`REG_ADDR_W-1:0] rs1_addr,
	output logic [`REG_ADDR_W-1:0] rs2_addr,
	output logic                  dec_valid,
	output logic [`XLEN_W-1:0]    dec_pc,
	output logic [`XLEN_W-1:0]    op_a,
	output logic [`XLEN_W-1:0]    op_b,
	output logic [`XLEN_W-1:0]    imm,
	output alu_op_t               alu_op,
	output branch_t               branch,
	output res_src_t              res_src,
	output logic                  mem_read,
	output logic                  mem_write,
	output logic [`REG_ADDR_W-1:0] rd,
	output logic                  halt_req,
	output logic                  illegal_req
);

	logic               insn_valid;
	logic [`XLEN_W-1:0] insn;
	logic [`XLEN_W-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
	logic [2:0]         funct3;
	opcode_t            opcode;
	logic               use_pc, use_imm, halt_cond, illegal_cond;

	function automatic alu_op_t alu_from_funct(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  return alt ? ALU_SUB : ALU_ADD;
			3'b001:  return ALU_SLL;
			3'b010:  return ALU_SLT;
			3'b011:  return ALU_SLTU;
			3'b100:  return ALU_XOR;
			3'b101:  return alt ? ALU_SRA : ALU_SRL;
			3'b110:  return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	function automatic branch_t branch_from_funct(input logic [2:0] f3);
		case (f3)
			3'b000:  return BR_EQ;
			3'b001:  return BR_NE;
			3'b100:  return BR_LT;
			3'b101:  return BR_GE;
			3'b110:  return BR_LTU;
			3'b111:  return BR_GEU;
			default: return BR_NONE;
		endcase
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			insn_valid <= 1'b0;
		end else begin
			insn_valid <= fetch_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_valid) begin
			insn   <= fetch_insn;
			dec_pc <= fetch_pc;
		end
	end

	assign opcode   = opcode_t'(insn[6:0]);
	assign funct3   = insn[14:12];
	assign rd       = insn[11:7];
	assign rs1_addr = insn[19:15];
	assign rs2_addr = insn[24:20];

	assign imm_i = {{20{insn[31]}}, insn[31:20]};
	assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
	assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
	assign imm_u = {insn[31:12], 12'b0};
	assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

	// Jumps and branches put the PC on operand A, except JALR which uses rs1.
	// Execute forms every jump target as op_a + imm.
	always_comb begin
		imm          = imm_i;
		alu_op       = ALU_ADD;
		branch       = BR_NONE;
		res_src      = RES_NONE;
		mem_read     = 1'b0;
		mem_write    = 1'b0;
		use_pc       = 1'b0;
		use_imm      = 1'b0;
		halt_cond    = 1'b0;
		illegal_cond = 1'b0;
		case (opcode)
			OP_LUI: begin
				imm     = imm_u;
				use_imm = 1'b1;
				alu_op  = ALU_PASS_B;
				res_src = RES_ALU;
			end
			OP_AUIPC: begin
				imm     = imm_u;
				use_pc  = 1'b1;
				use_imm = 1'b1;
				res_src = RES_ALU;
			end
			OP_JAL: begin
				imm     = imm_j;
				use_pc  = 1'b1;
				branch  = BR_ALWAYS;
				res_src = RES_LINK;
			end
			OP_JALR: begin
				branch  = BR_ALWAYS;
				res_src = RES_LINK;
			end
			OP_BRANCH: begin
				imm    = imm_b;
				use_pc = 1'b1;
				branch = branch_from_funct(funct3);
			end
			OP_LOAD: begin
				use_imm  = 1'b1;
				mem_read = 1'b1;
				res_src  = RES_MEM;
			end
			OP_STORE: begin
				imm       = imm_s;
				use_imm   = 1'b1;
				mem_write = 1'b1;
			end
			OP_IMM: begin
				use_imm = 1'b1;
				alu_op  = alu_from_funct(funct3, funct3 == 3'b101 && insn[30]);
				res_src = RES_ALU;
			end
			OP_REG: begin
				alu_op  = alu_from_funct(funct3, insn[30]);
				res_src = RES_ALU;
			end
			OP_SYSTEM: begin
				halt_cond    = 1'b1;
				illegal_cond = (insn != `INSN_EBREAK);
			end
			default: begin
				halt_cond    = 1'b1;
				illegal_cond = 1'b1;
			end
		endcase
	end

	assign op_a = use_pc ? dec_pc : rs1_data;
	assign op_b = use_imm ? imm : rs2_data;

	assign dec_valid   = insn_valid & ~halt_cond;
	assign halt_req    = insn_valid & halt_cond;
	assign illegal_req = insn_valid & illegal_cond;

endmodule

// ==== hdl/register_file.sv ====
`timescale 1ns/1ps
`include "core_consts.svh"

module register_file (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [`REG_ADDR_W-1:0] rs1_addr,
	input  logic [`REG_ADDR_W-1:0] rs2_addr,
	input  logic                   wen,
	input  logic [`REG_ADDR_W-1:0] wr_addr,
	input  logic [`XLEN_W-1:0]     wr_data,
	output logic [`XLEN_W-1:0]     rs1_data,
	output logic [`XLEN_W-1:0]     rs2_data
);

	// x0 has no storage.
	logic [`XLEN_W-1:0] regs [1:`NUM_REGS-1];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	always_comb begin
		rs1_data = '0;
		rs2_data = '0;
		if (rs1_addr != '0) begin
			rs1_data = regs[rs1_addr];
		end
		if (rs2_addr != '0) begin
			rs2_data = regs[rs2_addr];
		end
	end

	a_wr_addr_known: assert property (@(posedge clk) disable iff (!rst_n)
		wen |-> !$isunknown(wr_addr));

endmodule

// ==== hdl/execute_unit.sv ====
`timescale 1ns/1ps
`include "core_consts.svh"

module execute_unit import isa_pkg::*, core_pkg::*; (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   dec_valid,
	input  logic [`XLEN_W-1:0]     dec_pc,
	input  logic [`XLEN_W-1:0]     op_a,
	input  logic [`XLEN_W-1:0]     op_b,
	input  logic [`XLEN_W-1:0]     imm,
	input  logic [`XLEN_W-1:0]     rs1_val,
	input  logic [`XLEN_W-1:0]     rs2_val,
	input  alu_op_t                alu_op,
	input  branch_t                branch,
	input  res_src_t               res_src,
	input  logic                   mem_read,
	input  logic                   mem_write,
	input  logic [`REG_ADDR_W-1:0] rd,
	output logic                   ex_valid,
	output logic [`XLEN_W-1:0]     result,
	output logic [`XLEN_W-1:0]     mem_addr,
	output logic [`XLEN_W-1:0]     store_data,
	output logic [`XLEN_W-1:0]     next_pc,
	output logic [`XLEN_W-1:0]     ex_pc,
	output logic [`REG_ADDR_W-1:0] ex_rd,
	output res_src_t               ex_res_src,
	output logic                   ex_mem_read,
	output logic                   ex_mem_write
);

	logic [`XLEN_W-1:0] alu_res;
	logic [`XLEN_W-1:0] jump_sum;
	logic [4:0]         shamt;
	logic               taken;

	assign shamt = op_b[4:0];

	always_comb begin
		case (alu_op)
			ALU_ADD:    alu_res = op_a + op_b;
			ALU_SUB:    alu_res = op_a - op_b;
			ALU_SLL:    alu_res = op_a << shamt;
			ALU_SLT:    alu_res = {{(`XLEN_W-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			ALU_SLTU:   alu_res = {{(`XLEN_W-1){1'b0}}, op_a < op_b};
			ALU_XOR:    alu_res = op_a ^ op_b;
			ALU_SRL:    alu_res = op_a >> shamt;
			ALU_SRA:    alu_res = $signed(op_a) >>> shamt;
			ALU_OR:     alu_res = op_a | op_b;
			ALU_AND:    alu_res = op_a & op_b;
			ALU_PASS_B: alu_res = op_b;
			default:    alu_res = '0;
		endcase
	end

	always_comb begin
		case (branch)
			BR_EQ:     taken = (rs1_val == rs2_val);
			BR_NE:     taken = (rs1_val != rs2_val);
			BR_LT:     taken = ($signed(rs1_val) < $signed(rs2_val));
			BR_GE:     taken = ($signed(rs1_val) >= $signed(rs2_val));
			BR_LTU:    taken = (rs1_val < rs2_val);
			BR_GEU:    taken = (rs1_val >= rs2_val);
			BR_ALWAYS: taken = 1'b1;
			default:   taken = 1'b0;
		endcase
	end

	// Operand A is the PC for JAL and branches and rs1 for JALR. Bit 0 is
	// already zero in the PC-relative cases.
	assign jump_sum = op_a + imm;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_valid <= 1'b0;
		end else begin
			ex_valid <= dec_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (dec_valid) begin
			result       <= alu_res;
			mem_addr     <= rs1_val + imm;
			store_data   <= rs2_val;
			next_pc      <= taken ? {jump_sum[`XLEN_W-1:1], 1'b0} : dec_pc + 32'd4;
			ex_pc        <= dec_pc;
			ex_rd        <= rd;
			ex_res_src   <= res_src;
			ex_mem_read  <= mem_read;
			ex_mem_write <= mem_write;
		end
	end

endmodule

// ==== hdl/mem_unit.sv ====
`timescale 1ns/1ps
`include "core_consts.svh"

module mem_unit import core_pkg::*; (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   ex_valid,
	input  logic [`XLEN_W-1:0]     result,
	input  logic [`XLEN_W-1:0]     mem_addr,
	input  logic [`XLEN_W-1:0]     store_data,
	input  logic [`XLEN_W-1:0]     next_pc,
	input  logic [`XLEN_W-1:0]     ex_pc,
	input  logic [`REG_ADDR_W-1:0] ex_rd,
	input  res_src_t               ex_res_src,
	input  logic                   ex_mem_read,
	input  logic                   ex_mem_write,
	input  logic                   dmem_rvalid,
	input  logic [`XLEN_W-1:0]     dmem_rdata,
	output logic                   dmem_req,
	output logic                   dmem_we,
	output logic [`XLEN_W-1:0]     dmem_addr,
	output logic [`XLEN_W-1:0]     dmem_wdata,
	output logic                   retire,
	output logic [`XLEN_W-1:0]     retire_pc,
	output logic [`REG_ADDR_W-1:0] retire_rd,
	output logic                   retire_wen,
	output logic [`XLEN_W-1:0]     retire_data,
	output logic [`XLEN_W-1:0]     retire_next_pc
);

	logic               pending;
	logic               is_mem;
	logic               finish;
	logic [`XLEN_W-1:0] wb_value;

	// The execute registers stay stable until the next decode, so they are
	// still valid when a slow load or store comes back.
	assign is_mem = ex_mem_read | ex_mem_write;
	assign finish = (ex_valid & ~is_mem) | (pending & dmem_rvalid);

	always_comb begin
		case (ex_res_src)
			RES_ALU:  wb_value = result;
			RES_LINK: wb_value = ex_pc + 32'd4;
			RES_MEM:  wb_value = dmem_rdata;
			default:  wb_value = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dmem_req   <= 1'b0;
			pending    <= 1'b0;
			retire     <= 1'b0;
			retire_wen <= 1'b0;
		end else begin
			dmem_req   <= ex_valid & is_mem;
			retire     <= finish;
			retire_wen <= finish && ex_res_src != RES_NONE && ex_rd != '0;
			if (ex_valid && is_mem) begin
				pending <= 1'b1;
			end else if (dmem_rvalid) begin
				pending <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ex_valid) begin
			dmem_we    <= ex_mem_write;
			dmem_addr  <= mem_addr;
			dmem_wdata <= store_data;
		end
		if (finish) begin
			retire_pc      <= ex_pc;
			retire_rd      <= ex_rd;
			retire_data    <= wb_value;
			retire_next_pc <= next_pc;
		end
	end

	a_rvalid_pending: assert property (@(posedge clk) disable iff (!rst_n)
		dmem_rvalid |-> pending);

endmodule

// ==== hdl/rv_core.sv ====
`timescale 1ns/1ps
`include "core_consts.svh"

module rv_core import isa_pkg::*, core_pkg::*; (
	input  logic                   clk,
	input  logic                   rst_n,
	output logic                   imem_req,
	output logic [`XLEN_W-1:0]     imem_addr,
	input  logic                   imem_rvalid,
	input  logic [`XLEN_W-1:0]     imem_rdata,
	output logic                   dmem_req,
	output logic                   dmem_we,
	output logic [`XLEN_W-1:0]     dmem_addr,
	output logic [`XLEN_W-1:0]     dmem_wdata,
	input  logic                   dmem_rvalid,
	input  logic [`XLEN_W-1:0]     dmem_rdata,
	output logic                   retire,
	output logic [`XLEN_W-1:0]     retire_pc,
	output logic [`REG_ADDR_W-1:0] retire_rd,
	output logic                   retire_wen,
	output logic [`XLEN_W-1:0]     retire_data,
	output logic                   halted,
	output logic                   illegal
);

	// ********************
	// Stage signals
	// ********************

	logic                   fetch_valid, dec_valid, ex_valid;
	logic [`XLEN_W-1:0]     fetch_pc, fetch_insn, dec_pc, ex_pc;
	logic [`XLEN_W-1:0]     op_a, op_b, imm, rs1_data, rs2_data;
	logic [`XLEN_W-1:0]     result, mem_addr, store_data, next_pc, retire_next_pc;
	logic [`REG_ADDR_W-1:0] rs1_addr, rs2_addr, rd, ex_rd;
	alu_op_t                alu_op;
	branch_t                branch;
	res_src_t               res_src, ex_res_src;
	logic                   mem_read, mem_write, ex_mem_read, ex_mem_write;
	logic                   halt_req, illegal_req;

	fetch_unit u_fetch (
		.clk, .rst_n, .imem_rvalid, .imem_rdata, .retire,
		.next_pc(retire_next_pc), .halt_req, .illegal_req,
		.imem_req, .imem_addr, .fetch_valid, .fetch_pc, .fetch_insn,
		.halted, .illegal
	);

	decode_unit u_decode (
		.clk, .rst_n, .fetch_valid, .fetch_pc, .fetch_insn, .rs1_data, .rs2_data,
		.rs1_addr, .rs2_addr, .dec_valid, .dec_pc, .op_a, .op_b, .imm, .alu_op,
		.branch, .res_src, .mem_read, .mem_write, .rd, .halt_req, .illegal_req
	);

	register_file u_regs (
		.clk, .rst_n, .rs1_addr, .rs2_addr, .wen(retire_wen), .wr_addr(retire_rd),
		.wr_data(retire_data), .rs1_data, .rs2_data
	);

	execute_unit u_execute (
		.clk, .rst_n, .dec_valid, .dec_pc, .op_a, .op_b, .imm,
		.rs1_val(rs1_data), .rs2_val(rs2_data), .alu_op, .branch, .res_src,
		.mem_read, .mem_write, .rd, .ex_valid, .result, .mem_addr, .store_data,
		.next_pc, .ex_pc, .ex_rd, .ex_res_src, .ex_mem_read, .ex_mem_write
	);

	mem_unit u_mem (
		.clk, .rst_n, .ex_valid, .result, .mem_addr, .store_data, .next_pc, .ex_pc,
		.ex_rd, .ex_res_src, .ex_mem_read, .ex_mem_write, .dmem_rvalid, .dmem_rdata,
		.dmem_req, .dmem_we, .dmem_addr, .dmem_wdata, .retire, .retire_pc,
		.retire_rd, .retire_wen, .retire_data, .retire_next_pc
	);

endmodule

// ==== test/tb_core.sv ====
`timescale 1ns/1ps
`include "core_consts.svh"

module tb_core import isa_pkg::*;;

	localparam int IMEM_WORDS = 1024;
	localparam int DMEM_WORDS = 1024;
	localparam logic [31:0] SEED = 32'hfb8b2cbd;

	logic                   clk = 1'b0;
	logic                   rst_n = 1'b0;
	logic                   imem_req;
	logic [`XLEN_W-1:0]     imem_addr;
	logic                   imem_rvalid = 1'b0;
	logic [`XLEN_W-1:0]     imem_rdata = '0;
	logic                   dmem_req;
	logic                   dmem_we;
	logic [`XLEN_W-1:0]     dmem_addr;
	logic [`XLEN_W-1:0]     dmem_wdata;
	logic                   dmem_rvalid = 1'b0;
	logic [`XLEN_W-1:0]     dmem_rdata = '0;
	logic                   retire;
	logic [`XLEN_W-1:0]     retire_pc;
	logic [`REG_ADDR_W-1:0] retire_rd;
	logic                   retire_wen;
	logic [`XLEN_W-1:0]     retire_data;
	logic                   halted;
	logic                   illegal;

	logic [31:0] imem [0:IMEM_WORDS-1];
	logic [31:0] dmem [0:DMEM_WORDS-1];
	logic [31:0] prog [$];

	// Reference machine state.
	logic [31:0] ref_regs [0:31];
	logic [31:0] ref_dmem [0:DMEM_WORDS-1];
	logic [31:0] ref_pc;

	logic [31:0] gen_rng = SEED;
	logic [31:0] imem_rng = ~SEED;
	logic [31:0] dmem_rng = {SEED[15:0], SEED[31:16]};

	int          i_wait = 0;
	logic [31:0] i_addr;
	int          d_wait = 0;
	logic        d_we;
	logic [31:0] d_addr;
	logic [31:0] d_wdata;

	int cycles = 0;
	int run_start = 0;
	int timeout_limit = 0;
	int retired = 0;

	logic [31:0] e_pc, e_data, e_npc;
	logic [4:0]  e_rd;
	logic        e_wen, e_halt;

	rv_core dut0 (.*);

	always #20 clk = ~clk;

	// ********************
	// Helpers
	// ********************

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return (addr * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
	endfunction

	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OP_REG};
	endfunction

	function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
	endfunction

	function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
	endfunction

	function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
	endfunction

	task automatic emit(input logic [31:0] word);
		prog.push_back(word);
	endtask

	task automatic stop_with_failure();
		$display("TEST FAILED");
		$fatal(1, "Stopped at the first error.");
	endtask

	task automatic check_word(input string what, input logic [`XLEN_W-1:0] got,
		input logic [`XLEN_W-1:0] exp);
		if (got !== exp) begin
			$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_reg(input string what, input logic [`REG_ADDR_W-1:0] got,
		input logic [`REG_ADDR_W-1:0] exp);
		if (got !== exp) begin
			$display("ERR %0t: %s is x%0d, expected x%0d", $time, what, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
			stop_with_failure();
		end
	endtask

	// ********************
	// Reference model
	// ********************

	function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		logic [31:0] res;
		case (f3)
			3'b000: res = alt ? a - b : a + b;
			3'b001: res = a << b[4:0];
			3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b011: res = (a < b) ? 32'd1 : 32'd0;
			3'b100: res = a ^ b;
			3'b101: begin
				if (alt) begin
					res = $signed(a) >>> b[4:0];
				end else begin
					res = a >> b[4:0];
				end
			end
			3'b110: res = a | b;
			default: res = a & b;
		endcase
		return res;
	endfunction

	// EBREAK and every opcode outside the executed set stop the core.
	function automatic logic stops_core(input logic [31:0] insn);
		case (insn[6:0])
			OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH,
			OP_LOAD, OP_STORE, OP_IMM, OP_REG: return 1'b0;
			default: return 1'b1;
		endcase
	endfunction

	task automatic reset_model();
		ref_pc = `RESET_PC;
		for (int i = 0; i < 32; i++) begin
			ref_regs[i[4:0]] = '0;
		end
		for (int i = 0; i < DMEM_WORDS; i++) begin
			ref_dmem[i[9:0]] = fill_word({i[29:0], 2'b00});
		end
	endtask

	function automatic void step_model(output logic [31:0] pc, output logic [4:0] rd,
		output logic wen, output logic [31:0] data, output logic [31:0] npc,
		output logic halt);
		logic [31:0] insn, a, b, addr;
		logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;
		logic [2:0]  f3;
		logic        take;
		insn  = imem[ref_pc[11:2]];
		pc    = ref_pc;
		rd    = insn[11:7];
		f3    = insn[14:12];
		a     = ref_regs[insn[19:15]];
		b     = ref_regs[insn[24:20]];
		imm_i = {{20{insn[31]}}, insn[31:20]};
		imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
		imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
		imm_u = {insn[31:12], 12'h000};
		imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
		npc   = ref_pc + 32'd4;
		wen   = 1'b1;
		data  = '0;
		take  = 1'b0;
		halt  = stops_core(insn);
		case (insn[6:0])
			OP_LUI:   data = imm_u;
			OP_AUIPC: data = ref_pc + imm_u;
			OP_JAL: begin
				data = ref_pc + 32'd4;
				npc  = ref_pc + imm_j;
			end
			OP_JALR: begin
				data = ref_pc + 32'd4;
				addr = a + imm_i;
				npc  = {addr[31:1], 1'b0};
			end
			OP_BRANCH: begin
				wen = 1'b0;
				case (f3)
					3'b000:  take = (a == b);
					3'b001:  take = (a != b);
					3'b100:  take = ($signed(a) < $signed(b));
					3'b101:  take = ($signed(a) >= $signed(b));
					3'b110:  take = (a < b);
					3'b111:  take = (a >= b);
					default: take = 1'b0;
				endcase
				if (take) begin
					npc = ref_pc + imm_b;
				end
			end
			OP_LOAD: begin
				addr = a + imm_i;
				data = ref_dmem[addr[11:2]];
			end
			OP_STORE: begin
				wen  = 1'b0;
				addr = a + imm_s;
				ref_dmem[addr[11:2]] = b;
			end
			OP_IMM: data = alu_model(f3, f3 == 3'b101 && insn[30], a, imm_i);
			OP_REG: data = alu_model(f3, insn[30], a, b);
			default: wen = 1'b0;
		endcase
		if (rd == 5'd0) begin
			wen = 1'b0;
		end
		if (!halt) begin
			if (wen) begin
				ref_regs[rd] = data;
			end
			ref_pc = npc;
		end
	endfunction

	// ********************
	// Program
	// ********************

	task automatic build_program(input logic illegal_end);
		logic [31:0] r, r2, addr, marker;
		logic [4:0]  rd, rs1, rs2;
		logic [2:0]  f3;
		logic [11:0] imm;
		logic        alt;
		prog.delete();
		// Counts the instructions that were not skipped.
		marker = i_type(12'd1, 5'd31, 3'd0, 5'd31, OP_IMM);

		emit(i_type(12'hffb, 5'd0, 3'd0, 5'd1, OP_IMM));
		emit(i_type(12'd3, 5'd0, 3'd0, 5'd2, OP_IMM));
		emit(i_type(12'd3, 5'd0, 3'd0, 5'd3, OP_IMM));
		// Pairs are equal, negative against positive, and positive against negative.
		for (int c = 0; c < 8; c++) begin
			if (c != 2 && c != 3) begin
				for (int p = 0; p < 3; p++) begin
					rs1 = (p == 1) ? 5'd1 : 5'd2;
					rs2 = (p == 0) ? 5'd3 : ((p == 1) ? 5'd2 : 5'd1);
					emit(b_type(13'd8, rs2, rs1, c[2:0]));
					emit(marker);
				end
			end
		end

		emit(u_type(20'h12345, 5'd5, OP_LUI));
		emit(u_type(20'h00010, 5'd6, OP_AUIPC));
		emit(j_type(21'd12, 5'd7));
		emit(marker);
		emit(marker);
		// JALR targets with bit 0 set land one word past the skipped marker.
		emit(u_type(20'h00000, 5'd8, OP_AUIPC));
		emit(i_type(12'd13, 5'd8, 3'd0, 5'd9, OP_JALR));
		emit(marker);
		emit(j_type(21'd8, 5'd0));
		emit(marker);
		emit(u_type(20'h00000, 5'd8, OP_AUIPC));
		emit(i_type(12'd13, 5'd8, 3'd0, 5'd0, OP_JALR));
		emit(marker);

		emit(i_type(12'h100, 5'd0, 3'd0, 5'd10, OP_IMM));
		emit(u_type(20'hcafe1, 5'd11, OP_LUI));
		emit(i_type(12'h234, 5'd11, 3'd0, 5'd11, OP_IMM));
		emit(s_type(12'd0, 5'd11, 5'd10));
		emit(i_type(12'd0, 5'd10, 3'b010, 5'd12, OP_LOAD));
		emit(s_type(12'd4, 5'd1, 5'd10));
		emit(i_type(12'd4, 5'd10, 3'b010, 5'd13, OP_LOAD));
		emit(i_type(12'd0, 5'd10, 3'b010, 5'd14, OP_LOAD));
		emit(i_type(12'd64, 5'd10, 3'b010, 5'd15, OP_LOAD));
		emit(s_type(12'hffc, 5'd2, 5'd10));
		emit(i_type(12'hffc, 5'd10, 3'b010, 5'd16, OP_LOAD));
		emit(i_type(12'd4, 5'd10, 3'b010, 5'd0, OP_LOAD));
		emit(r_type(7'h00, 5'd13, 5'd12, 3'b000, 5'd17));
		emit(s_type(12'd8, 5'd17, 5'd10));
		emit(i_type(12'd8, 5'd10, 3'b010, 5'd18, OP_LOAD));

		for (int n = 0; n < 200; n++) begin
			gen_rng = lcg_step(gen_rng);
			r       = gen_rng;
			gen_rng = lcg_step(gen_rng);
			r2      = gen_rng;
			rd      = (n % 25 == 0) ? 5'd0 : r[15:11];
			rs1     = r[20:16];
			rs2     = r[25:21];
			f3      = r[28:26];
			alt     = r[29] && (f3 == 3'b000 || f3 == 3'b101);
			if (r[30]) begin
				emit(r_type({1'b0, alt, 5'b00000}, rs2, rs1, f3, rd));
			end else begin
				imm = r2[27:16];
				if (f3 == 3'b001) begin
					imm = {7'b0000000, r2[20:16]};
				end else if (f3 == 3'b101) begin
					imm = {1'b0, r[29], 5'b00000, r2[20:16]};
				end
				emit(i_type(imm, rs1, f3, rd, OP_IMM));
			end
		end

		emit(illegal_end ? 32'h0000_000b : `INSN_EBREAK);

		// Unused words hold an unknown opcode, so a stray fetch stops the core.
		for (int i = 0; i < IMEM_WORDS; i++) begin
			addr = {i[29:0], 2'b00};
			imem[i[9:0]] = {addr[24:0], 7'h7f};
		end
		for (int k = 0; k < prog.size(); k++) begin
			imem[k[9:0]] = prog[k];
		end
	endtask

	// ********************
	// Memory models
	// ********************

	always begin
		@(posedge clk);
		#1;
		imem_rvalid = 1'b0;
		if (!rst_n) begin
			i_wait = 0;
		end else begin
			if (imem_req) begin
				if (i_wait != 0) begin
					$display("A new instruction request came while another was still open");
					stop_with_failure();
				end
				imem_rng = lcg_step(imem_rng);
				i_wait   = 1 + int'(imem_rng >> 16) % 3;
				i_addr   = imem_addr;
			end
			if (i_wait != 0) begin
				i_wait--;
				if (i_wait == 0) begin
					imem_rvalid = 1'b1;
					imem_rdata  = imem[i_addr[11:2]];
				end
			end
		end
	end

	always begin
		@(posedge clk);
		#1;
		dmem_rvalid = 1'b0;
		if (!rst_n) begin
			d_wait = 0;
			for (int i = 0; i < DMEM_WORDS; i++) begin
				dmem[i[9:0]] = fill_word({i[29:0], 2'b00});
			end
		end else begin
			if (dmem_req) begin
				if (d_wait != 0) begin
					$display("A new data request came while another was still open");
					stop_with_failure();
				end
				dmem_rng = lcg_step(dmem_rng);
				d_wait   = 1 + int'(dmem_rng >> 16) % 4;
				d_we     = dmem_we;
				d_addr   = dmem_addr;
				d_wdata  = dmem_wdata;
			end
			if (d_wait != 0) begin
				d_wait--;
				if (d_wait == 0) begin
					dmem_rvalid = 1'b1;
					if (d_we) begin
						dmem[d_addr[11:2]] = d_wdata;
					end else begin
						dmem_rdata = dmem[d_addr[11:2]];
					end
				end
			end
		end
	end

	// ********************
	// Checking
	// ********************

	always @(negedge clk) begin
		if (!rst_n) begin
			reset_model();
			e_npc = `RESET_PC;
		end else begin
			// A fetch goes to the reset PC or to the next PC of the last retire.
			if (imem_req) begin
				check_word("imem_addr", imem_addr, e_npc);
			end
			if (retire) begin
				step_model(e_pc, e_rd, e_wen, e_data, e_npc, e_halt);
				if (e_halt) begin
					$display("The core retired the halting instruction at PC %h", e_pc);
					stop_with_failure();
				end else begin
					check_word("retire_pc", retire_pc, e_pc);
					check_flag("retire_wen", retire_wen, e_wen);
					if (e_wen) begin
						check_reg("retire_rd", retire_rd, e_rd);
						check_word("retire_data", retire_data, e_data);
					end
					retired++;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (timeout_limit > 0 && cycles - run_start > timeout_limit) begin
			$display("Timeout: the core did not halt within %0d cycles", timeout_limit);
			stop_with_failure();
		end
	end

	task automatic run_program(input logic illegal_end);
		logic [31:0] insn;
		build_program(illegal_end);
		@(posedge clk);
		#1;
		rst_n = 1'b0;
		repeat (10) begin
			@(negedge clk);
		end
		check_flag("imem_req in reset", imem_req, 1'b0);
		check_flag("halted in reset", halted, 1'b0);
		check_flag("illegal in reset", illegal, 1'b0);
		@(posedge clk);
		#1;
		rst_n         = 1'b1;
		retired       = 0;
		run_start     = cycles;
		timeout_limit = 20 * prog.size();
		while (!halted) begin
			@(negedge clk);
		end
		timeout_limit = 0;
		insn = imem[ref_pc[11:2]];
		if (!stops_core(insn)) begin
			$display("The core halted at PC %h, where the next instruction should run", ref_pc);
			stop_with_failure();
		end
		check_word("imem_addr at halt", imem_addr, ref_pc);
		check_flag("illegal", illegal, insn != `INSN_EBREAK);
		repeat (10) begin
			@(negedge clk);
			check_flag("imem_req after halt", imem_req, 1'b0);
			check_flag("halted", halted, 1'b1);
		end
		$display("Run finished after %0d retired instructions", retired);
	endtask

	initial begin
		run_program(1'b0);
		run_program(1'b1);
		$display("TEST OK");
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+hdl
hdl/isa_pkg.sv
hdl/core_pkg.sv
hdl/fetch_unit.sv
hdl/decode_unit.sv
hdl/register_file.sv
hdl/execute_unit.sv
hdl/mem_unit.sv
hdl/rv_core.sv
test/tb_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_core
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)
